//--- rtl/pong_defs.svh
// pong constants
// screen geometry, ball and paddle sizes, speeds and start positions

`ifndef PONG_DEFS_SVH
`define PONG_DEFS_SVH

`define CORDW       10      // screen coordinate width

// 480p raster, 800x525 total
`define H_RES       640     // active pixels per line
`define V_RES       480     // active lines per frame
`define H_FP        16      // horizontal front porch
`define H_SYNC      96      // hsync width
`define H_BP        48      // horizontal back porch
`define V_FP        10      // vertical front porch
`define V_SYNC      2       // vsync width in lines
`define V_BP        33      // vertical back porch

// ball
`define B_SIZE      8       // side in pixels
`define BALL_SPEED  2       // pixels per frame, both axes
`define BALL_X0     626     // near right edge, bounces early
`define BALL_Y0     466     // near bottom edge

// paddles
`define P_H         40      // height
`define P_W         10      // width
`define P_SP        1       // pixels per frame
`define P_OFFS      32      // gap to left/right screen edge
`define P_Y0        200     // top after reset

`endif

//--- rtl/pong_pkg.sv
// pong shared types
// raster position, sync bundle, object position and vga output

`default_nettype none

`include "pong_defs.svh"

package pong_pkg;

    // current raster coordinate
    typedef struct packed {
        logic [`CORDW-1:0] sx;  // pixel in line
        logic [`CORDW-1:0] sy;  // line in frame
    } pix_pos_t;

    // raster control, sync active low
    typedef struct packed {
        logic hsync;
        logic vsync;
        logic de;       // inside 640x480
    } sync_t;

    // top-left corner of a ball or paddle
    typedef struct packed {
        logic [`CORDW-1:0] x;
        logic [`CORDW-1:0] y;
    } obj_pos_t;

    // registered vga pins
    typedef struct packed {
        logic       hsync;
        logic       vsync;
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } vga_out_t;

endpackage

`default_nettype wire

//--- rtl/display_timing_480p.sv
// 640x480 @ 60 Hz raster timing
// pixel/line counters, active low syncs, data enable and frame tick

`default_nettype none

`include "pong_defs.svh"

module display_timing_480p
    import pong_pkg::*;
(
    input  wire logic clk_pix,     // pixel clock
    input  wire logic reset,       // sync, active high
    output pix_pos_t  pos,         // current raster coordinate
    output sync_t     sync,        // syncs and data enable
    output logic      frame_tick   // one cycle, start of vblank
);

    // line/frame boundaries
    localparam int HS_STA = `H_RES + `H_FP;             // 656
    localparam int HS_END = HS_STA + `H_SYNC;           // 752
    localparam int LINE   = HS_END + `H_BP;             // 800
    localparam int VS_STA = `V_RES + `V_FP;             // 490
    localparam int VS_END = VS_STA + `V_SYNC;           // 492
    localparam int SCREEN = VS_END + `V_BP;             // 525

    localparam logic [`CORDW-1:0] H_LAST = `CORDW'(LINE - 1);
    localparam logic [`CORDW-1:0] V_LAST = `CORDW'(SCREEN - 1);

    // raster counters
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            pos.sx <= '0;
            pos.sy <= '0;
        end else if (pos.sx == H_LAST) begin  // end of line
            pos.sx <= '0;
            pos.sy <= (pos.sy == V_LAST) ? '0 : pos.sy + 1'b1;
        end else begin
            pos.sx <= pos.sx + 1'b1;
        end
    end

    // syncs straight from the counters, low inside the pulse
    always_comb begin
        sync.hsync = ~((pos.sx >= `CORDW'(HS_STA)) && (pos.sx < `CORDW'(HS_END)));
        sync.vsync = ~((pos.sy >= `CORDW'(VS_STA)) && (pos.sy < `CORDW'(VS_END)));
        sync.de    = (pos.sx < `CORDW'(`H_RES)) && (pos.sy < `CORDW'(`V_RES));
    end

    // first pixel of first blanking line
    // game objects update here, well clear of the visible area
    always_comb begin
        frame_tick = (pos.sy == `CORDW'(`V_RES)) && (pos.sx == '0);
    end

endmodule

`default_nettype wire

//--- rtl/ball_motion.sv
// ball motion
// moves the ball once per frame, bounces off the active area edges

`default_nettype none

`include "pong_defs.svh"

module ball_motion
    import pong_pkg::*;
(
    input  wire logic clk_pix,     // pixel clock
    input  wire logic reset,       // sync, active high
    input  wire logic frame_tick,  // once per frame
    output obj_pos_t  ball         // top-left of ball
);

    localparam logic [`CORDW-1:0] SPEED = `CORDW'(`BALL_SPEED);

    // last position before a step would leave the screen
    localparam logic [`CORDW-1:0] X_LIM = `CORDW'(`H_RES - (`BALL_SPEED + `B_SIZE));
    localparam logic [`CORDW-1:0] Y_LIM = `CORDW'(`V_RES - (`BALL_SPEED + `B_SIZE));

    logic dx;  // 0 right, 1 left
    logic dy;  // 0 down, 1 up

    logic [`CORDW:0] x_next;  // {dir, pos}
    logic [`CORDW:0] y_next;

    // one axis step with bounce
    // far edge forces dir 1, near edge forces dir 0
    function automatic logic [`CORDW:0] step_axis(
        input logic [`CORDW-1:0] p,
        input logic              d,
        input logic [`CORDW-1:0] lim
    );
        logic              nd;
        logic [`CORDW-1:0] np;
        if (p >= lim) begin         // far edge, turn back
            nd = 1'b1;
            np = p - SPEED;
        end else if (p < SPEED) begin  // near edge
            nd = 1'b0;
            np = p + SPEED;
        end else begin
            nd = d;
            np = d ? p - SPEED : p + SPEED;
        end
        return {nd, np};
    endfunction

    always_comb begin
        x_next = step_axis(ball.x, dx, X_LIM);
        y_next = step_axis(ball.y, dy, Y_LIM);
    end

    // position and direction registers
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            ball.x <= `CORDW'(`BALL_X0);
            ball.y <= `CORDW'(`BALL_Y0);
            dx     <= 1'b0;  // right
            dy     <= 1'b0;  // down
        end else if (frame_tick) begin
            dx     <= x_next[`CORDW];
            ball.x <= x_next[`CORDW-1:0];
            dy     <= y_next[`CORDW];
            ball.y <= y_next[`CORDW-1:0];
        end
    end

endmodule

`default_nettype wire

//--- rtl/paddle_ai.sv
// computer paddle
// follows the ball centre vertically, one step per frame, kept on screen

`default_nettype none

`include "pong_defs.svh"

module paddle_ai
    import pong_pkg::*;
#(
    parameter logic [`CORDW-1:0] PADDLE_X = `CORDW'(`P_OFFS)  // left column
) (
    input  wire logic     clk_pix,     // pixel clock
    input  wire logic     reset,       // sync, active high
    input  wire logic     frame_tick,  // once per frame
    input  wire obj_pos_t ball,        // ball before this update
    output obj_pos_t      paddle       // top-left of paddle
);

    localparam int W = `CORDW + 1;  // room for centre sums

    localparam logic [W-1:0] P_HALF  = W'(`P_H / 2);
    localparam logic [W-1:0] B_HALF  = W'(`B_SIZE / 2);
    localparam logic [W-1:0] DEADBND = W'(`P_SP / 2);  // ignore tiny offsets

    localparam logic [`CORDW-1:0] STEP   = `CORDW'(`P_SP);
    localparam logic [`CORDW-1:0] DN_LIM = `CORDW'(`V_RES - `P_H - `P_SP);

    logic [`CORDW-1:0] py;     // paddle top
    logic [W-1:0]      p_mid;  // paddle centre
    logic [W-1:0]      b_mid;  // ball centre
    logic              go_dn;
    logic              go_up;

    always_comb begin
        p_mid = {1'b0, py} + P_HALF;
        b_mid = {1'b0, ball.y} + B_HALF;
        // ball below centre, and room left above the bottom limit
        go_dn = (p_mid + DEADBND < b_mid) && (py <= DN_LIM);
        // ball above, and a full step left before row 0
        go_up = (p_mid > b_mid + DEADBND) && (py >= STEP);
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            py <= `CORDW'(`P_Y0);
        end else if (frame_tick) begin
            if (go_dn) begin
                py <= py + STEP;
            end else if (go_up) begin
                py <= py - STEP;
            end
        end
    end

    // column fixed
    always_comb begin
        paddle.x = PADDLE_X;
        paddle.y = py;
    end

endmodule

`default_nettype wire

//--- rtl/pong_renderer.sv
// pong renderer
// hit tests of ball and paddles against the raster, registered vga out

`default_nettype none

`include "pong_defs.svh"

module pong_renderer
    import pong_pkg::*;
(
    input  wire logic     clk_pix,   // pixel clock
    input  wire logic     reset,     // sync, active high
    input  wire pix_pos_t pos,       // current raster coordinate
    input  wire sync_t    sync,      // syncs for pos
    input  wire obj_pos_t ball,
    input  wire obj_pos_t paddle_l,
    input  wire obj_pos_t paddle_r,
    output vga_out_t      vga        // one cycle after pos
);

    localparam int W = `CORDW + 1;

    logic b_hit;
    logic pl_hit;
    logic pr_hit;
    logic lit;

    // is pixel p inside a w x h box at o
    function automatic logic covers(
        input pix_pos_t p,
        input obj_pos_t o,
        input int       w,
        input int       h
    );
        logic [W-1:0] x_end;
        logic [W-1:0] y_end;
        x_end = {1'b0, o.x} + W'(w);  // one past right column
        y_end = {1'b0, o.y} + W'(h);
        return (p.sx >= o.x) && ({1'b0, p.sx} < x_end)
            && (p.sy >= o.y) && ({1'b0, p.sy} < y_end);
    endfunction

    always_comb begin
        b_hit  = covers(pos, ball, `B_SIZE, `B_SIZE);
        pl_hit = covers(pos, paddle_l, `P_W, `P_H);
        pr_hit = covers(pos, paddle_r, `P_W, `P_H);
        lit    = sync.de && (b_hit || pl_hit || pr_hit);  // nothing in blanking
    end

    // output stage, syncs delayed with the colour
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            vga <= '{hsync: 1'b1, vsync: 1'b1, r: 4'h0, g: 4'h0, b: 4'h0};
        end else begin
            vga.hsync <= sync.hsync;
            vga.vsync <= sync.vsync;
            vga.r     <= lit ? 4'hF : 4'h0;  // monochrome
            vga.g     <= lit ? 4'hF : 4'h0;
            vga.b     <= lit ? 4'hF : 4'h0;
        end
    end

endmodule

`default_nettype wire

//--- rtl/pong_top.sv
// pong video top level
// raster timing, ball, two computer paddles and the vga renderer

`default_nettype none

`include "pong_defs.svh"

module pong_top
    import pong_pkg::*;
(
    input  wire logic clk_pix,  // 25.2 MHz pixel clock
    input  wire logic reset,    // sync, active high
    output vga_out_t  vga       // to the vga connector
);

    pix_pos_t pos;         // raster coordinate
    sync_t    sync;        // syncs and de for pos
    logic     frame_tick;  // start of vblank
    obj_pos_t ball;
    obj_pos_t paddle_l;
    obj_pos_t paddle_r;

    display_timing_480p dt0 (
        .clk_pix    (clk_pix),
        .reset      (reset),
        .pos        (pos),
        .sync       (sync),
        .frame_tick (frame_tick)
    );

    ball_motion ball0 (
        .clk_pix    (clk_pix),
        .reset      (reset),
        .frame_tick (frame_tick),
        .ball       (ball)
    );

    // left paddle
    paddle_ai #(
        .PADDLE_X (`CORDW'(`P_OFFS))
    ) pad_l (
        .clk_pix    (clk_pix),
        .reset      (reset),
        .frame_tick (frame_tick),
        .ball       (ball),
        .paddle     (paddle_l)
    );

    // right paddle, mirrored column
    paddle_ai #(
        .PADDLE_X (`CORDW'(`H_RES - `P_OFFS - `P_W))
    ) pad_r (
        .clk_pix    (clk_pix),
        .reset      (reset),
        .frame_tick (frame_tick),
        .ball       (ball),
        .paddle     (paddle_r)
    );

    pong_renderer rend0 (
        .clk_pix  (clk_pix),
        .reset    (reset),
        .pos      (pos),
        .sync     (sync),
        .ball     (ball),
        .paddle_l (paddle_l),
        .paddle_r (paddle_r),
        .vga      (vga)
    );

endmodule

`default_nettype wire

//--- test/tb_pong.sv
// pong testbench
// reference model of raster, ball and paddles, vga output checked per pixel

`default_nettype none

`include "pong_defs.svh"

module tb_pong
    import pong_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_NS = 20;
    localparam int LINE   = `H_RES + `H_FP + `H_SYNC + `H_BP;  // 800 pixels
    localparam int FRAME  = `V_RES + `V_FP + `V_SYNC + `V_BP;  // 525 lines
    localparam int HS_STA = `H_RES + `H_FP;                    // 656
    localparam int VS_STA = `V_RES + `V_FP;                    // 490
    localparam int PL_X   = `P_OFFS;
    localparam int PR_X   = `H_RES - `P_OFFS - `P_W;
    localparam int TIMEOUT_NS = 7 * LINE * FRAME * CLK_NS + 2_000_000;  // 7 frames + margin

    logic     clk_pix;
    logic     reset;
    vga_out_t vga;

    // model state, tracks the dut registers
    int   m_sx;
    int   m_sy;
    int   m_bx;
    int   m_by;
    logic m_left;            // ball heading left
    logic m_up;              // ball heading up
    int   m_pl;              // left paddle top
    int   m_pr;              // right paddle top
    int   frame_cnt = 0;     // raster wraps, not cleared by reset
    logic checking  = 1'b0;  // set once the first reset is seen

    // expected output, one cycle behind the model raster
    vga_out_t    exp_vga;
    pix_pos_t    exp_pos;
    logic        exp_de;
    logic [11:0] exp_rgb;
    logic [11:0] vga_rgb;

    int err_hsync = 0;
    int err_vsync = 0;
    int err_blank = 0;
    int err_pixel = 0;

    logic [31:0] rnd;
    int          reset_line;  // line of the mid-run reset
    int          f_rel;

    assign vga_rgb = {vga.r, vga.g, vga.b};
    assign exp_rgb = {exp_vga.r, exp_vga.g, exp_vga.b};

    pong_top dut0 (
        .clk_pix (clk_pix),
        .reset   (reset),
        .vga     (vga)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // pixel inside a w x h box at (ox, oy)
    function automatic logic in_box(input int px, input int py, input int ox,
                                    input int oy, input int w, input int h);
        return (px >= ox) && (px < ox + w) && (py >= oy) && (py < oy + h);
    endfunction

    // one ball axis per frame, turns back when the next step would reach an edge
    task automatic bounce_axis(inout int p, inout logic back, input int res);
        if (p + `BALL_SPEED + `B_SIZE >= res) begin
            back = 1'b1;
            p    = p - `BALL_SPEED;
        end else if (p < `BALL_SPEED) begin  // would go negative
            back = 1'b0;
            p    = p + `BALL_SPEED;
        end else begin
            p = back ? p - `BALL_SPEED : p + `BALL_SPEED;
        end
    endtask

    // paddle top chasing the ball centre, stays on screen
    function automatic int track_ball(input int py, input int by);
        int pmid;
        int bmid;
        pmid = py + `P_H / 2;
        bmid = by + `B_SIZE / 2;
        if ((pmid + `P_SP / 2 < bmid) && (py + `P_SP <= `V_RES - `P_H)) begin
            return py + `P_SP;
        end
        if ((pmid > bmid + `P_SP / 2) && (py - `P_SP >= 0)) begin
            return py - `P_SP;
        end
        return py;
    endfunction

    // reference model
    always @(posedge clk_pix) begin : model
        int   nbx;
        int   nby;
        logic nleft;
        logic nup;
        logic lit;
        if (reset) begin
            m_sx     <= 0;
            m_sy     <= 0;
            m_bx     <= `BALL_X0;
            m_by     <= `BALL_Y0;
            m_left   <= 1'b0;  // right and down
            m_up     <= 1'b0;
            m_pl     <= `P_Y0;
            m_pr     <= `P_Y0;
            exp_vga  <= '{hsync: 1'b1, vsync: 1'b1, r: 4'h0, g: 4'h0, b: 4'h0};
            exp_de   <= 1'b0;
            checking <= 1'b1;
        end else begin
            lit = in_box(m_sx, m_sy, m_bx, m_by, `B_SIZE, `B_SIZE)
                || in_box(m_sx, m_sy, PL_X, m_pl, `P_W, `P_H)
                || in_box(m_sx, m_sy, PR_X, m_pr, `P_W, `P_H);
            exp_de        <= (m_sx < `H_RES) && (m_sy < `V_RES);
            exp_pos.sx    <= `CORDW'(m_sx);
            exp_pos.sy    <= `CORDW'(m_sy);
            exp_vga.hsync <= !((m_sx >= HS_STA) && (m_sx < HS_STA + `H_SYNC));
            exp_vga.vsync <= !((m_sy >= VS_STA) && (m_sy < VS_STA + `V_SYNC));
            lit = lit && (m_sx < `H_RES) && (m_sy < `V_RES);  // dark in blanking
            exp_vga.r     <= lit ? 4'hF : 4'h0;
            exp_vga.g     <= lit ? 4'hF : 4'h0;
            exp_vga.b     <= lit ? 4'hF : 4'h0;

            // raster counters
            if (m_sx == LINE - 1) begin
                m_sx <= 0;
                if (m_sy == FRAME - 1) begin
                    m_sy      <= 0;
                    frame_cnt <= frame_cnt + 1;
                end else begin
                    m_sy <= m_sy + 1;
                end
            end else begin
                m_sx <= m_sx + 1;
            end

            // game update at the start of vblank
            if ((m_sx == 0) && (m_sy == `V_RES)) begin
                nbx   = m_bx;
                nby   = m_by;
                nleft = m_left;
                nup   = m_up;
                bounce_axis(nbx, nleft, `H_RES);
                bounce_axis(nby, nup, `V_RES);
                m_pl   <= track_ball(m_pl, m_by);  // old ball
                m_pr   <= track_ball(m_pr, m_by);
                m_bx   <= nbx;
                m_by   <= nby;
                m_left <= nleft;
                m_up   <= nup;
            end
        end
    end

    // checks against the delayed model
    a_hsync: assert property (@(posedge clk_pix) checking |-> vga.hsync == exp_vga.hsync)
        else begin
            err_hsync = err_hsync + 1;
            $display("** Error hsync at (%0d,%0d): expected %b, actual %b",
                     $sampled(exp_pos.sx), $sampled(exp_pos.sy),
                     $sampled(exp_vga.hsync), $sampled(vga.hsync));
        end

    a_vsync: assert property (@(posedge clk_pix) checking |-> vga.vsync == exp_vga.vsync)
        else begin
            err_vsync = err_vsync + 1;
            $display("** Error vsync at (%0d,%0d): expected %b, actual %b",
                     $sampled(exp_pos.sx), $sampled(exp_pos.sy),
                     $sampled(exp_vga.vsync), $sampled(vga.vsync));
        end

    a_blank: assert property (@(posedge clk_pix) checking && !exp_de |-> vga_rgb == 12'h000)
        else begin
            err_blank = err_blank + 1;
            $display("** Error blank at (%0d,%0d): expected %h, actual %h",
                     $sampled(exp_pos.sx), $sampled(exp_pos.sy), 12'h000, $sampled(vga_rgb));
        end

    a_pixel: assert property (@(posedge clk_pix) checking && exp_de |-> vga_rgb == exp_rgb)
        else begin
            err_pixel = err_pixel + 1;
            $display("** Error pixel at (%0d,%0d) frame %0d: expected %h, actual %h",
                     $sampled(exp_pos.sx), $sampled(exp_pos.sy), $sampled(frame_cnt),
                     $sampled(exp_rgb), $sampled(vga_rgb));
        end

    initial begin
        clk_pix = 1'b0;
        forever #(CLK_NS / 2) clk_pix = ~clk_pix;
    end

    // watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("timeout: run did not finish within %0d ns", TIMEOUT_NS);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        reset      = 1'b1;
        rnd        = lcg_next(32'h0e28_7553);
        reset_line = int'(rnd[31:16] % 16'd480);  // somewhere in frame 4
        repeat (2) @(posedge clk_pix);
        reset <= 1'b0;

        // frames 0 to 3, reset frame then edge bounces
        while (!((frame_cnt == 4) && (m_sy == reset_line))) begin
            @(posedge clk_pix);
        end
        reset <= 1'b1;  // second reset mid frame
        repeat (2) @(posedge clk_pix);
        reset <= 1'b0;
        f_rel = frame_cnt;

        // fresh reset frame, then one more frame of motion
        while (frame_cnt < f_rel + 2) begin
            @(posedge clk_pix);
        end
        repeat (4) @(posedge clk_pix);

        $display("errors: hsync %0d, vsync %0d, blank %0d, pixel %0d",
                 err_hsync, err_vsync, err_blank, err_pixel);
        if (err_hsync + err_vsync + err_blank + err_pixel == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+rtl
rtl/pong_pkg.sv
rtl/display_timing_480p.sv
rtl/ball_motion.sv
rtl/paddle_ai.sv
rtl/pong_renderer.sv
rtl/pong_top.sv
test/tb_pong.sv

//--- run_sim.sh
#!/bin/sh
# build and run the pong testbench with verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_pong -f verilog.f -o tb_pong_sim

./obj_dir/tb_pong_sim > "$LOG"
cat "$LOG"

# the testbench prints its verdict, look for the failure line
if grep -q "Finished with errors" "$LOG"; then
    echo "simulation FAILED, see $LOG"
    exit 1
fi
echo "simulation passed"
